// File: source/div_pkg.sv
/* divide unit
   shared types and constants */

`default_nettype none

package div_pkg;

  ////////////////////
  // widths
  ////////////////////

  // widest XLEN the packed structs can carry
  localparam int XLEN_MAX = 64;

  ////////////////////
  // enums
  ////////////////////

  // divide kinds, W forms share these and set the word flag
  typedef enum logic [2:0] {
    DIV     = 3'd0,  // signed quotient
    DIVU    = 3'd1,  // unsigned quotient
    REM     = 3'd2,  // signed remainder
    REMU    = 3'd3,  // unsigned remainder
    OP_NONE = 3'd4   // not a divide
  } div_op_e;

  // machine width from status, misa MXL encoding
  typedef enum logic [1:0] {
    RV32I  = 2'b01,
    RV64I  = 2'b10,
    RV128I = 2'b11
  } xlen_e;

  ////////////////////
  // instr fields
  ////////////////////

  localparam logic [6:0] OPC_OP    = 7'b011_0011;  // register-register ops
  localparam logic [6:0] OPC_OP32  = 7'b011_1011;  // 32-bit word ops, rv64 and up
  localparam logic [6:0] F7_MULDIV = 7'b000_0001;  // M extension

  // func3 of the divide group, mul kinds use 0xx
  localparam logic [2:0] F3_DIV  = 3'b100;
  localparam logic [2:0] F3_DIVU = 3'b101;
  localparam logic [2:0] F3_REM  = 3'b110;
  localparam logic [2:0] F3_REMU = 3'b111;

  ////////////////////
  // structs
  ////////////////////

  // prep -> core, modules use the low XLEN bits of the operands
  typedef struct packed {
    div_op_e               op;
    logic                  word;      // W form
    logic                  neg_q;     // negate quotient at the end
    logic                  neg_r;     // negate remainder at the end
    logic [XLEN_MAX-1:0]   dividend;  // magnitude, word ops at the top
    logic [XLEN_MAX-1:0]   divisor;   // magnitude
  } div_req_t;

  // instruction info kept by the core for the fixup stage
  typedef struct packed {
    div_op_e op;
    logic    word;
    logic    neg_q;
    logic    neg_r;
  } div_tag_t;

endpackage

`default_nettype wire

// File: source/div_prep.sv
/* divide operand preparation */

`timescale 1ns/10ps
`default_nettype none

module div_prep #(
  parameter int XLEN = 64
) (
  input  div_pkg::xlen_e    st_xlen,
  input  logic              ex_stall,
  input  logic              id_bubble,
  input  logic              idle,        // core ready for a new op
  input  logic [31:0]       id_instr,
  input  logic [XLEN-1:0]   op_a,
  input  logic [XLEN-1:0]   op_b,
  output logic              start,       // iterate this op
  output logic              spec_valid,  // resolved without iterating
  output logic [XLEN-1:0]   spec_result,
  output div_pkg::div_req_t req
);

  import div_pkg::*;

  logic [6:0]      opcode;
  logic [2:0]      func3;
  logic [6:0]      func7;
  logic            is_op;
  logic            is_op32;
  logic            word;
  div_op_e         op;
  logic            sgn;      // signed kind
  logic            is_quo;   // quotient wanted
  logic [XLEN-1:0] a_sext;
  logic [XLEN-1:0] ea;       // effective operands
  logic [XLEN-1:0] eb;
  logic            sign_a;
  logic            sign_b;
  logic [XLEN-1:0] abs_a;
  logic [XLEN-1:0] abs_b;
  logic [XLEN-1:0] min_val;  // most negative value of the op width
  logic            div_zero;
  logic            ovf;
  logic            issue;

  ////////////////////
  // decode
  ////////////////////

  assign opcode = id_instr[6:0];
  assign func3  = id_instr[14:12];
  assign func7  = id_instr[31:25];

  assign is_op   = opcode == OPC_OP;
  // W forms only exist on a 64-bit datapath running wider than rv32
  assign is_op32 = (XLEN > 32) && (opcode == OPC_OP32) && (st_xlen != RV32I);
  assign word    = is_op32;

  always_comb begin
    op = OP_NONE;
    if (func7 == F7_MULDIV && (is_op || is_op32)) begin
      case (func3)
        F3_DIV:  op = DIV;
        F3_DIVU: op = DIVU;
        F3_REM:  op = REM;
        F3_REMU: op = REMU;
        default: op = OP_NONE;  // multiply group
      endcase
    end
  end

  assign issue = idle && !ex_stall && !id_bubble && (op != OP_NONE);

  ////////////////////
  // operands
  ////////////////////

  assign sgn    = (op == DIV) || (op == REM);
  assign is_quo = (op == DIV) || (op == DIVU);
  assign a_sext = XLEN'($signed(op_a[31:0]));

  // word ops look at the low half only, upper bits are don't care
  always_comb begin
    if (!word) begin
      ea = op_a;
      eb = op_b;
    end else if (sgn) begin
      ea = a_sext;
      eb = XLEN'($signed(op_b[31:0]));
    end else begin
      ea = XLEN'(op_a[31:0]);
      eb = XLEN'(op_b[31:0]);
    end
  end

  assign sign_a = sgn & ea[XLEN-1];
  assign sign_b = sgn & eb[XLEN-1];
  assign abs_a  = sign_a ? -ea : ea;  // MIN stays MIN, fine as unsigned
  assign abs_b  = sign_b ? -eb : eb;

  ////////////////////
  // special cases
  ////////////////////

  assign min_val  = word ? XLEN'($signed(32'h8000_0000)) : {1'b1, {(XLEN-1){1'b0}}};
  assign div_zero = ~|eb;
  assign ovf      = sgn && (ea == min_val) && (&eb);  // MIN / -1

  always_comb begin
    if (div_zero)
      spec_result = is_quo ? '1 : (word ? a_sext : op_a);  // -1 or dividend
    else
      spec_result = is_quo ? min_val : '0;                 // overflow
  end

  assign spec_valid = issue && (div_zero || ovf);
  assign start      = issue && !div_zero && !ovf;

  // request to the core
  assign req.op       = op;
  assign req.word     = word;
  assign req.neg_q    = sign_a ^ sign_b;
  assign req.neg_r    = sign_a;                // remainder follows the dividend
  assign req.dividend = XLEN_MAX'(word ? (abs_a << (XLEN-32)) : abs_a);
  assign req.divisor  = XLEN_MAX'(abs_b);

endmodule

`default_nettype wire

// File: source/div_core.sv
/* restoring divider core */

`timescale 1ns/10ps
`default_nettype none

module div_core #(
  parameter int XLEN = 64
) (
  input  logic              clk,
  input  logic              rstn,
  input  logic              start,
  input  div_pkg::div_req_t req,
  output logic              idle,
  output logic              done,       // raw result valid, one cycle
  output logic              div_stall,
  output div_pkg::div_tag_t tag,        // kept for the fixup stage
  output logic [XLEN-1:0]   quo,
  output logic [XLEN-1:0]   rem
);

  localparam int CNT_W = $clog2(XLEN);

  typedef enum logic [1:0] {
    CHK,  // wait for an op
    DIV,  // one bit per cycle
    RES   // hand result to fixup
  } state_e;

  state_e            state;
  logic [CNT_W-1:0]  cnt;
  logic [XLEN-1:0]   pa_p;   // partial remainder
  logic [XLEN-1:0]   pa_a;   // dividend in, quotient out
  logic [XLEN-1:0]   b;      // divisor
  logic [XLEN:0]     p_sh;   // shifted remainder, needs the carry bit
  logic [XLEN+1:0]   diff;
  logic              neg;

  ////////////////////
  // fsm
  ////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= CHK;
      cnt   <= '0;
    end else begin
      case (state)
        CHK: if (start) begin
          state <= DIV;
          cnt   <= req.word ? CNT_W'(31) : CNT_W'(XLEN-1);  // 32 or XLEN passes
        end
        DIV: begin
          cnt <= cnt - 1'b1;
          if (cnt == '0) state <= RES;
        end
        RES:     state <= CHK;
        default: state <= CHK;
      endcase
    end
  end

  ////////////////////
  // shift-subtract
  ////////////////////

  // p_sh can reach 2b-1, so compare with one extra bit
  assign p_sh = {pa_p, pa_a[XLEN-1]};
  assign diff = {1'b0, p_sh} - {2'b00, b};
  assign neg  = diff[XLEN+1];

  always_ff @(posedge clk) begin
    if (state == CHK && start) begin
      pa_p <= '0;
      pa_a <= req.dividend[XLEN-1:0];
      b    <= req.divisor[XLEN-1:0];
      tag  <= '{op: req.op, word: req.word, neg_q: req.neg_q, neg_r: req.neg_r};
    end else if (state == DIV) begin
      pa_p <= neg ? p_sh[XLEN-1:0] : diff[XLEN-1:0];  // restore or keep difference
      pa_a <= {pa_a[XLEN-2:0], ~neg};                 // quotient bit in
    end
  end

  // word ops end with the quotient in the low 32 bits
  assign quo = pa_a;
  assign rem = pa_p;

  assign idle      = state == CHK;
  assign div_stall = state != CHK;  // high through RES, drops with it
  assign done      = state == RES;

endmodule

`default_nettype wire

// File: source/div_post.sv
/* divide result fixup */

`timescale 1ns/10ps
`default_nettype none

module div_post #(
  parameter int XLEN = 64
) (
  input  logic              clk,
  input  logic              rstn,
  input  logic              done,
  input  logic              spec_valid,
  input  div_pkg::div_tag_t tag,
  input  logic [XLEN-1:0]   quo,
  input  logic [XLEN-1:0]   rem,
  input  logic [XLEN-1:0]   spec_result,
  output logic              div_bubble,  // active low result strobe
  output logic [XLEN-1:0]   div_r
);

  import div_pkg::*;

  logic            is_quo;
  logic [XLEN-1:0] signed_val;
  logic [XLEN-1:0] fixed;

  assign is_quo = (tag.op == DIV) || (tag.op == DIVU);

  // pick the half, then undo the magnitude
  always_comb begin
    if (is_quo)
      signed_val = tag.neg_q ? -quo : quo;
    else
      signed_val = tag.neg_r ? -rem : rem;
  end

  assign fixed = tag.word ? XLEN'($signed(signed_val[31:0])) : signed_val;  // W: sext bit 31

  ////////////////////
  // output register
  ////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      div_bubble <= 1'b1;
      div_r      <= '0;
    end else begin
      div_bubble <= 1'b1;  // default, low for one cycle only
      if (spec_valid) begin
        div_r      <= spec_result;  // no iteration
        div_bubble <= 1'b0;
      end else if (done) begin
        div_r      <= fixed;
        div_bubble <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/div_unit.sv
/* integer divide unit */

`timescale 1ns/10ps
`default_nettype none

module div_unit #(
  parameter int XLEN = 64  // 32 or 64
) (
  input  logic            clk,
  input  logic            rstn,
  input  logic            ex_stall,
  input  logic            id_bubble,
  input  logic [31:0]     id_instr,
  input  logic [XLEN-1:0] op_a,
  input  logic [XLEN-1:0] op_b,
  input  div_pkg::xlen_e  st_xlen,
  output logic            div_stall,
  output logic            div_bubble,
  output logic [XLEN-1:0] div_r
);

  import div_pkg::*;

  // prep -> core / post
  logic            start;
  logic            spec_valid;
  logic [XLEN-1:0] spec_result;
  div_req_t        req;

  // core -> prep / post
  logic            idle;
  logic            done;
  div_tag_t        tag;
  logic [XLEN-1:0] quo;
  logic [XLEN-1:0] rem;

  ////////////////////
  // stages
  ////////////////////

  div_prep #(.XLEN(XLEN)) u_prep (
    .st_xlen     (st_xlen),
    .ex_stall    (ex_stall),
    .id_bubble   (id_bubble),
    .idle        (idle),
    .id_instr    (id_instr),
    .op_a        (op_a),
    .op_b        (op_b),
    .start       (start),
    .spec_valid  (spec_valid),
    .spec_result (spec_result),
    .req         (req)
  );

  div_core #(.XLEN(XLEN)) u_core (
    .clk       (clk),
    .rstn      (rstn),
    .start     (start),
    .req       (req),
    .idle      (idle),
    .done      (done),
    .div_stall (div_stall),
    .tag       (tag),
    .quo       (quo),
    .rem       (rem)
  );

  div_post #(.XLEN(XLEN)) u_post (
    .clk         (clk),
    .rstn        (rstn),
    .done        (done),
    .spec_valid  (spec_valid),
    .tag         (tag),
    .quo         (quo),
    .rem         (rem),
    .spec_result (spec_result),
    .div_bubble  (div_bubble),
    .div_r       (div_r)
  );

endmodule

`default_nettype wire

// File: bench/div_unit_tb.sv
/* divide unit testbench */

`timescale 1ns/10ps
`default_nettype none

module div_unit_tb;

  import div_pkg::*;

  localparam int          XLEN       = 64;
  localparam int          RST_CYCLES = 5;
  localparam int          MAX_TESTS  = 64;
  localparam int          NO_RESULT  = -1;
  localparam int          NONE_WAIT  = 34;                     // edges watched for a stray result
  localparam logic [63:0] END_MARK   = 64'h0000_0000_ffff_ffff;

  logic            clk;
  logic            rstn;
  logic            ex_stall;
  logic            id_bubble;
  logic [31:0]     id_instr;
  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  xlen_e           st_xlen;
  logic            div_stall;
  logic            div_bubble;
  logic [XLEN-1:0] div_r;

  logic [63:0] pat [0:5*MAX_TESTS-1];  // instr, xlen, a, b, result
  int          n_tests;
  int          errors;
  int          checks;
  logic [15:0] lfsr;

  div_unit #(.XLEN(XLEN)) UUT (
    .clk        (clk),
    .rstn       (rstn),
    .ex_stall   (ex_stall),
    .id_bubble  (id_bubble),
    .id_instr   (id_instr),
    .op_a       (op_a),
    .op_b       (op_b),
    .st_xlen    (st_xlen),
    .div_stall  (div_stall),
    .div_bubble (div_bubble),
    .div_r      (div_r)
  );

  always #4 clk = ~clk;  // 8 ns

  ////////////////////
  // helpers
  ////////////////////

  // galois, taps 16,14,13,11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [7:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[6:0], lfsr[0]};  // one step per bit
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %0t ns %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  // edge after issue that carries the result, RISC-V M rules
  function automatic int result_edge(input logic [31:0] instr, input logic [1:0] xl,
                                     input logic [63:0] a, input logic [63:0] b);
    logic [6:0] opc;
    logic [2:0] f3;
    logic       word;
    logic       zero;
    logic       ovf;
    opc  = instr[6:0];
    f3   = instr[14:12];
    word = opc == 7'h3b;
    if (instr[31:25] != 7'h01 || !f3[2]) return NO_RESULT;        // mul group or other
    if (opc != 7'h33 && !(word && xl != 2'b01)) return NO_RESULT;  // W needs rv64
    zero = word ? (b[31:0] == '0) : (b == '0);
    ovf  = !f3[0] && (word ? (a[31:0] == 32'h8000_0000 && b[31:0] == '1)
                           : (a == 64'h8000_0000_0000_0000 && b == '1));
    if (zero || ovf) return 0;
    return word ? 33 : XLEN + 1;
  endfunction

  task automatic present(input int t);
    id_instr <= pat[5*t][31:0];
    st_xlen  <= xlen_e'(pat[5*t+1][1:0]);
    op_a     <= pat[5*t+2];
    op_b     <= pat[5*t+3];
  endtask

  // same instr held back by a stall or bubble, no result allowed
  task automatic drive_blocked(input int t);
    logic [7:0] r;
    take_bits(2, r);
    @(posedge clk);
    present(t);
    id_bubble <= r[0];
    ex_stall  <= !r[0] | r[1];  // at least one blocker
    @(negedge clk);
    compare("div_bubble", 64'd1, 64'(div_bubble));
  endtask

  task automatic run_test(input int t);
    logic [7:0] gap;
    logic [7:0] r;
    int         exp_edge;
    int         lim;
    int         k;
    exp_edge = result_edge(pat[5*t][31:0], pat[5*t+1][1:0], pat[5*t+2], pat[5*t+3]);
    lim      = (exp_edge == NO_RESULT) ? NONE_WAIT : exp_edge + 2;
    take_bits(3, gap);
    repeat (gap) drive_blocked(t);
    @(posedge clk);  // issue
    present(t);
    id_bubble <= 1'b0;
    ex_stall  <= 1'b0;
    @(negedge clk);
    compare("div_bubble", 64'd1, 64'(div_bubble));  // last result lasted one cycle
    k = 0;
    forever begin
      @(posedge clk);  // E(k)
      if (k < exp_edge) begin
        take_bits(3, r);  // noise while busy
        id_bubble <= r[0];
        ex_stall  <= r[1];
        id_instr  <= r[2] ? 32'h0220_f1b3 : pat[5*t][31:0];
        op_a      <= ~pat[5*t+2];
        op_b      <= ~pat[5*t+3];
      end else begin
        id_bubble <= 1'b1;
        ex_stall  <= 1'b0;
      end
      @(negedge clk);
      if (!div_bubble || k == lim) break;
      compare("div_stall", 64'(k < exp_edge), 64'(div_stall));
      k++;
    end
    if (exp_edge == NO_RESULT) begin
      compare("div_bubble", 64'd1, 64'(div_bubble));
    end else begin
      compare("result edge", 64'(exp_edge), 64'(k));
      compare("div_stall", 64'd0, 64'(div_stall));
      compare("div_r", pat[5*t+4], div_r);
    end
  endtask

  ////////////////////
  // main
  ////////////////////

  initial begin
    clk       = 1'b0;
    rstn      = 1'b0;
    ex_stall  = 1'b0;
    id_bubble = 1'b1;
    id_instr  = '0;
    op_a      = '0;
    op_b      = '0;
    st_xlen   = RV64I;
    errors    = 0;
    checks    = 0;
    n_tests   = 0;
    lfsr      = 16'd93;
    for (int i = 0; i < 5*MAX_TESTS; i++) pat[i] = END_MARK;
    $readmemh("bench/div_patterns.txt", pat);
    while (n_tests < MAX_TESTS && pat[5*n_tests] != END_MARK) n_tests++;
    if (n_tests == 0) begin
      $display("no test patterns could be read from bench/div_patterns.txt");
      errors++;
    end
    repeat (RST_CYCLES) @(posedge clk);
    rstn <= 1'b1;
    @(negedge clk);
    compare("div_bubble", 64'd1, 64'(div_bubble));  // reset state
    compare("div_stall", 64'd0, 64'(div_stall));
    compare("div_r", 64'd0, div_r);
    for (int t = 0; t < n_tests; t++) run_test(t);
    @(posedge clk);
    id_bubble <= 1'b1;
    @(negedge clk);
    compare("div_bubble", 64'd1, 64'(div_bubble));
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // watchdog, budget per pattern plus reset
  initial begin
    #1;
    repeat (n_tests * (XLEN + 10) + RST_CYCLES + 4) @(posedge clk);
    $display("timeout: the tests did not finish within the cycle budget");
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/div_patterns.txt
// instr    xlen  op_a             op_b             expected div_r   (xlen 1 = RV32I, 2 = RV64I)
// ffffffff in the instr column ends the list; W on RV32I and MUL give no result
0220c1b3 2 0000000000000064 0000000000000007 000000000000000e
0220c1b3 2 ffffffffffffff9c 0000000000000007 fffffffffffffff2
0220c1b3 2 0000000000000064 fffffffffffffff9 fffffffffffffff2
0220c1b3 2 ffffffffffffff9c fffffffffffffff9 000000000000000e
0220e1b3 2 0000000000000064 0000000000000007 0000000000000002
0220e1b3 2 ffffffffffffff9c 0000000000000007 fffffffffffffffe
0220e1b3 2 0000000000000064 fffffffffffffff9 0000000000000002
0220e1b3 2 ffffffffffffff9c fffffffffffffff9 fffffffffffffffe
0220d1b3 2 ffffffffffffffff 0000000000000002 7fffffffffffffff
0220f1b3 2 ffffffffffffffff 0000000000000002 0000000000000001
0220d1b3 2 0000001000000000 0000000000000003 0000000555555555
0220f1b3 2 0000001000000000 0000000000000003 0000000000000001
0220c1b3 2 fffffff000000000 0000000000000003 fffffffaaaaaaaab
0220d1b3 2 8000000000000000 ffffffffffffffff 0000000000000000
0220f1b3 2 8000000000000000 ffffffffffffffff 8000000000000000
0220c1b3 2 8000000000000001 ffffffffffffffff 7fffffffffffffff
0220c1bb 2 deadbeef00000064 12345678fffffff9 fffffffffffffff2
0220d1bb 2 aaaaaaaaffffffff 5555555500000001 ffffffffffffffff
0220d1bb 2 33333333ffffff9c 0123456700000007 0000000024924916
0220e1bb 2 11111111ffffff9c 2222222200000007 fffffffffffffffe
0220f1bb 2 33333333ffffff9c 0123456700000007 0000000000000002
0220c1bb 2 0f0f0f0f80000000 f0f0f0f000000002 ffffffffc0000000
0220c1b3 2 0000000000001234 0000000000000000 ffffffffffffffff
0220e1b3 2 ffffffffffffff9c 0000000000000000 ffffffffffffff9c
0220f1b3 2 0000000000001234 0000000000000000 0000000000001234
0220c1b3 2 8000000000000000 ffffffffffffffff 8000000000000000
0220e1b3 2 8000000000000000 ffffffffffffffff 0000000000000000
0220c1bb 2 5a5a5a5a12345678 abcd000000000000 ffffffffffffffff
0220e1bb 2 1234567887654321 ffffffff00000000 ffffffff87654321
0220c1bb 2 ffff000080000000 00000001ffffffff ffffffff80000000
0220e1bb 2 ffff000080000000 00000001ffffffff 0000000000000000
0220c1bb 1 0000000000000064 0000000000000007 0000000000000000
022081b3 2 0000000000000064 0000000000000007 0000000000000000
0220c1b3 1 0000000000000064 0000000000000007 000000000000000e
ffffffff 0 0000000000000000 0000000000000000 0000000000000000

// File: verilog.f
source/div_pkg.sv
source/div_prep.sv
source/div_core.sv
source/div_post.sv
source/div_unit.sv
bench/div_unit_tb.sv

// File: Makefile
# Verilator flow for the divide unit

VERILATOR ?= verilator
TOP       ?= div_unit_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
SIMFLAGS  ?= -Wno-fatal
PASS_MSG  ?= All checks passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) $(SIMFLAGS) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(OBJ_DIR)

# status follows the pass line in the output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
